/* filelist.f */
+incdir+include
logic/mips_isa_pkg.sv
logic/mips_core_pkg.sv
logic/mips_decode.sv
logic/mips_regfile.sv
logic/mips_alu.sv
logic/mips_pc_unit.sv
logic/mips_writeback.sv
logic/mips_core.sv
test/mips_core_chk.sv
test/mips_core_tb.sv

/* Makefile */
# Verilator simulation of the mips core testbench

VERILATOR ?= verilator
TOP       ?= mips_core_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# build and run, exit status is the test result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* test/mips_core_tb.sv */
// ------------------------------
// mips core testbench
// builds a random program with its expected stores,
// models rom and ram, follows every fetch and store
// of the core until the final syscall halts it
// ------------------------------
`timescale 1ns/100ps
`include "mips_macros.svh"

module mips_core_tb;
   import mips_isa_pkg::*;
   import mips_core_pkg::*;

   localparam int          CLK_PERIOD  = 20;
   localparam int          SEED_INIT   = 63424;
   localparam int          ROM_WORDS   = 512;
   localparam int          RAM_WORDS   = 1024;
   localparam int          NUM_ITER    = 4;
   localparam logic [29:0] TEXT_WORD   = 30'(`MIPS_TEXT_START >> 2);
   localparam logic [15:0] STORE_BASE  = 16'h0400;  // result area, byte address
   localparam logic [15:0] POISON_ADDR = 16'h0fa0;  // wrong-path stores land here
   localparam reg_idx_t    R_A = 5'd8;
   localparam reg_idx_t    R_B = 5'd9;
   localparam reg_idx_t    R_T = 5'd10;
   localparam reg_idx_t    R_J = 5'd12;

   logic        clk;
   logic        rst_b;
   logic [29:0] inst_addr;
   instr_t      inst;
   dmem_req_t   dmem_req;
   word_t       dmem_rdata;
   logic        halted;

   logic [31:0] rom [ROM_WORDS];
   word_t       ram [RAM_WORDS];
   logic [29:0] exp_next [ROM_WORDS];  // expected fetch after each rom slot
   logic [29:0] exp_addr [256];
   word_t       exp_val  [256];
   logic [8:0]  pc_n;      // next free rom slot
   logic [7:0]  st_n;      // stores expected
   logic [7:0]  st_seen;   // stores observed
   logic [29:0] rom_off;
   integer      seed;
   logic        built;

   mips_core mips_core_i (
      .clk        (clk),
      .rst_b      (rst_b),
      .inst_addr  (inst_addr),
      .inst       (inst),
      .dmem_req   (dmem_req),
      .dmem_rdata (dmem_rdata),
      .halted     (halted)
   );

   bind mips_core mips_core_chk chk_i (
      .clk       (clk),
      .rst_b     (rst_b),
      .inst_addr (inst_addr),
      .inst      (inst),
      .dmem_req  (dmem_req),
      .halted    (halted)
   );

   // combinational rom, nop outside the text window
   assign rom_off = inst_addr - TEXT_WORD;
   assign inst    = instr_t'((rom_off < 30'(ROM_WORDS)) ? rom[rom_off[8:0]] : 32'h0);

   // combinational ram read, write at the rising edge
   assign dmem_rdata = ram[dmem_req.addr[9:0]];
   always @(posedge clk) begin
      if (dmem_req.we) ram[dmem_req.addr[9:0]] <= dmem_req.wdata;
   end

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic logic [31:0] r_type(funct_e fn, reg_idx_t rs, reg_idx_t rt,
                                          reg_idx_t rd, logic [4:0] sh);
      return {OP_SPECIAL, rs, rt, rd, sh, fn};
   endfunction

   function automatic logic [31:0] i_type(opcode_e op, reg_idx_t rs, reg_idx_t rt,
                                          logic [15:0] im);
      return {op, rs, rt, im};
   endfunction

   function automatic logic [29:0] word_of(logic [8:0] idx);
      return TEXT_WORD + 30'(idx);  // rom slot to fetch address
   endfunction

   function automatic word_t sext16(logic [15:0] v);
      return {{16{v[15]}}, v};
   endfunction

   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("** FAIL **");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic emit(input logic [31:0] w);
      rom[pc_n]      = w;
      exp_next[pc_n] = word_of(pc_n + 9'd1);  // sequential by default
      pc_n           = pc_n + 9'd1;
   endtask

   task automatic load_const(input reg_idx_t r, input word_t v);
      emit(i_type(OP_LUI, 5'd0, r, v[31:16]));
      emit(i_type(OP_ORI, r, r, v[15:0]));
   endtask

   // sw of r into the next result slot, value recorded
   task automatic expect_store(input reg_idx_t r, input word_t v);
      logic [15:0] off;
      off = STORE_BASE + {6'd0, st_n, 2'b00};
      emit(i_type(OP_SW, 5'd0, r, off));
      exp_addr[st_n] = {16'd0, off[15:2]};
      exp_val[st_n]  = v;
      st_n           = st_n + 8'd1;
   endtask

   task automatic put_poison();
      emit(i_type(OP_SW, 5'd0, 5'd0, POISON_ADDR));  // never expected
   endtask

   task automatic rop_store(input funct_e fn, input logic [4:0] sh, input word_t v);
      emit(r_type(fn, R_A, R_B, R_T, sh));
      expect_store(R_T, v);
   endtask

   task automatic iop_store(input opcode_e op, input reg_idx_t rs, input logic [15:0] im,
                            input word_t v);
      emit(i_type(op, rs, R_T, im));
      expect_store(R_T, v);
   endtask

   // branch one slot ahead; taken skips a poison, untaken runs a nop
   task automatic branch_check(input opcode_e op, input reg_idx_t rt, input logic taken);
      logic [8:0] at;
      at = pc_n;
      emit(i_type(op, R_A, rt, 16'd1));
      if (taken) begin
         exp_next[at] = word_of(at + 9'd2);
         put_poison();
      end else begin
         emit(32'h0);
      end
   endtask

   task automatic jump_over(input opcode_e op);
      logic [8:0]  at;
      logic [29:0] dest;
      at   = pc_n;
      dest = word_of(at + 9'd2);
      emit({op, dest[25:0]});
      exp_next[at] = dest;
      put_poison();
   endtask

   task automatic build_program();
      word_t       a;
      word_t       b;
      word_t       ld;
      logic [15:0] im;
      logic [4:0]  sh;
      logic [8:0]  at;
      logic [8:0]  tgt;
      for (int k = 0; k < NUM_ITER; k++) begin
         a  = $random(seed);
         b  = $random(seed);
         sh = 5'($random(seed));
         im = 16'($random(seed)) | 16'h8000;  // negative when sign-extended
         load_const(R_A, a);
         load_const(R_B, b);
         rop_store(FN_ADDU, sh, a + b);
         rop_store(FN_SUBU, sh, a - b);
         rop_store(FN_AND,  sh, a & b);
         rop_store(FN_OR,   sh, a | b);
         rop_store(FN_XOR,  sh, a ^ b);
         rop_store(FN_NOR,  sh, ~(a | b));
         rop_store(FN_SLT,  sh, {31'd0, $signed(a) < $signed(b)});
         rop_store(FN_SLL,  sh, b << sh);
         rop_store(FN_SRL,  sh, b >> sh);
         rop_store(FN_SRA,  sh, word_t'($signed(b) >>> sh));
         rop_store(FN_SLLV, sh, b << a[4:0]);  // amount from rs
         rop_store(FN_SRLV, sh, b >> a[4:0]);
         iop_store(OP_ADDIU, R_A, im, a + sext16(im));
         iop_store(OP_SLTI,  R_A, im, {31'd0, $signed(a) < $signed(sext16(im))});
         iop_store(OP_ANDI,  R_A, im, a & {16'd0, im});
         iop_store(OP_ORI,   R_A, im, a | {16'd0, im});
         iop_store(OP_XORI,  R_A, im, a ^ {16'd0, im});
         iop_store(OP_LUI,   5'd0, im, {im, 16'd0});
         // alternate sign bits of byte and half per word
         ram[k][7]  = k[0];
         ram[k][15] = !k[0];
         ld = ram[k];
         iop_store(OP_LW,  5'd0, 16'(4 * k), ld);
         iop_store(OP_LB,  5'd0, 16'(4 * k), {{24{ld[7]}}, ld[7:0]});
         iop_store(OP_LBU, 5'd0, 16'(4 * k), {24'd0, ld[7:0]});
         iop_store(OP_LH,  5'd0, 16'(4 * k), sext16(ld[15:0]));
         iop_store(OP_LHU, 5'd0, 16'(4 * k), {16'd0, ld[15:0]});
      end
      a = $random(seed);
      load_const(R_A, a);
      load_const(R_B, a ^ 32'd1);  // differs from r8
      branch_check(OP_BEQ, R_A, 1'b1);
      branch_check(OP_BNE, R_A, 1'b0);
      branch_check(OP_BNE, R_B, 1'b1);
      branch_check(OP_BEQ, R_B, 1'b0);
      jump_over(OP_J);
      at = pc_n;
      jump_over(OP_JAL);
      expect_store(`MIPS_REG_RA, {word_of(at), 2'b00} + 32'd4);  // link = jal + 4
      tgt = pc_n + 9'd4;  // past li pair, jr and poison
      load_const(R_J, {word_of(tgt), 2'b00});
      at = pc_n;
      emit(r_type(FN_JR, R_J, 5'd0, 5'd0, 5'd0));
      exp_next[at] = word_of(tgt);
      put_poison();
      expect_store(R_A, a);  // proves the jr landing
      at = pc_n;
      emit(r_type(FN_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
      exp_next[at] = word_of(at);  // pc frozen from here
      put_poison();
   endtask

   // store seen in this cycle against the next table entry
   task automatic check_store();
      if (dmem_req.we) begin
         assert (st_seen < st_n)
            else stop_on_error($sformatf("FAILED %0d ns: unexpected store to word %h",
                                         $time, dmem_req.addr));
         assert (dmem_req.addr == exp_addr[st_seen] && dmem_req.wdata == exp_val[st_seen])
            else stop_on_error($sformatf(
               "FAILED %0d ns: store %0d wrote %h to word %h, expected %h to word %h",
               $time, st_seen, dmem_req.wdata, dmem_req.addr,
               exp_val[st_seen], exp_addr[st_seen]));
         st_seen = st_seen + 8'd1;
      end
   endtask

   initial begin
      logic [29:0] cur;
      int          after_halt;
      rst_b      = 1'b1;
      seed       = SEED_INIT;
      built      = 1'b0;
      pc_n       = '0;
      st_n       = '0;
      st_seen    = '0;
      after_halt = 0;
      for (int i = 0; i < ROM_WORDS; i++) begin
         rom[i]      = 32'h0;  // nop
         exp_next[i] = word_of(9'(i + 1));
      end
      for (int i = 0; i < RAM_WORDS; i++) begin
         ram[i] = $random(seed);
      end
      build_program();
      built = 1'b1;
      @(negedge clk);
      rst_b = 1'b0;
      repeat (16) @(negedge clk);
      rst_b = 1'b1;
      cur = inst_addr;
      // follow fetches and stores until a few cycles into the halt
      while (after_halt < 4) begin
         check_store();
         @(negedge clk);
         assert (inst_addr == exp_next[9'(cur - TEXT_WORD)])
            else stop_on_error($sformatf("FAILED %0d ns: fetch after %h went to %h, expected %h",
                                         $time, cur, inst_addr, exp_next[9'(cur - TEXT_WORD)]));
         cur = inst_addr;
         if (halted) begin
            // store under the frozen pc, halted core must neither move nor write
            if (after_halt == 0) begin
               rom[9'(cur - TEXT_WORD)] = i_type(OP_SW, 5'd0, 5'd0, POISON_ADDR);
            end
            after_halt++;
         end
      end
      if (st_seen == st_n) begin
         $display("** PASS **");
         $finish;
      end else begin
         stop_on_error($sformatf("FAILED %0d ns: %0d of %0d expected stores seen",
                                 $time, st_seen, st_n));
      end
   end

   // checker assertions raise the count
   always @(negedge clk) begin
      if (mips_core_i.chk_i.fail_cnt != 0) stop_on_error("a checker assertion failed");
   end

   initial begin
      wait (built);
      #((int'(pc_n) + 16 + 100) * CLK_PERIOD);
      stop_on_error("watchdog expired before the core halted");
   end

endmodule

/* test/mips_core_chk.sv */
// ------------------------------
// mips core checker
// reset state, halt timing and
// frozen core after syscall
// ------------------------------
`timescale 1ns/100ps
`include "mips_macros.svh"

module mips_core_chk (
   input logic                     clk,
   input logic                     rst_b,
   input logic [29:0]              inst_addr,
   input mips_isa_pkg::instr_t     inst,
   input mips_core_pkg::dmem_req_t dmem_req,
   input logic                     halted
);
   import mips_isa_pkg::*;
   import mips_core_pkg::*;

   localparam logic [29:0] RESET_WORD = 30'(`MIPS_TEXT_START >> 2);

   int unsigned fail_cnt = 0;  // read by the testbench
   logic        is_syscall;
   logic        reset_seen;    // first reset pulse has started

   assign is_syscall = (inst.op == OP_SPECIAL) && (inst.funct == FN_SYSCALL);

   always @(posedge clk or negedge rst_b) begin
      if (!rst_b) reset_seen <= 1'b1;
   end

   reset_state: assert property (@(posedge clk)
      !rst_b |-> (inst_addr == RESET_WORD) && !halted && !dmem_req.we)
      else begin fail_cnt++; $error("core left its reset state during reset"); end

   reset_exit: assert property (@(posedge clk)
      reset_seen && $rose(rst_b) |-> (inst_addr == RESET_WORD) && !halted && !dmem_req.we)
      else begin fail_cnt++; $error("first cycle after reset not at reset pc"); end

   // halt exactly one edge after syscall
   halt_on_syscall: assert property (@(posedge clk) disable iff (!rst_b)
      is_syscall && !halted |=> halted)
      else begin fail_cnt++; $error("syscall did not halt the core"); end

   halt_cause: assert property (@(posedge clk) disable iff (!rst_b)
      $rose(halted) |-> $past(is_syscall))
      else begin fail_cnt++; $error("halted rose without a syscall"); end

   halt_frozen_pc: assert property (@(posedge clk) disable iff (!rst_b)
      halted |=> $stable(inst_addr))
      else begin fail_cnt++; $error("fetch address moved after halt"); end

   halt_no_store: assert property (@(posedge clk) disable iff (!rst_b)
      halted |-> !dmem_req.we)
      else begin fail_cnt++; $error("store issued after halt"); end

endmodule

/* logic/mips_core.sv */
// ------------------------------
// mips single-cycle core
// one instruction retired per clock, combinational
// instruction and data memories outside
// ------------------------------
`timescale 1ns/100ps

module mips_core (
   input  logic                     clk,
   input  logic                     rst_b,
   output logic [29:0]              inst_addr,
   input  mips_isa_pkg::instr_t     inst,
   output mips_core_pkg::dmem_req_t dmem_req,
   input  mips_isa_pkg::word_t      dmem_rdata,
   output logic                     halted
);
   import mips_isa_pkg::*;
   import mips_core_pkg::*;

   ctrl_t       ctrl;
   word_t       imm;
   reg_idx_t    wr_reg;
   logic [25:0] target;
   word_t       rs_data, rt_data;
   word_t       alu_result;
   word_t       wr_data;
   word_t       pc, pc_plus4;

   mips_decode decode_i (
      .inst    (inst),
      .halted  (halted),
      .ctrl    (ctrl),
      .imm     (imm),
      .wr_reg  (wr_reg),
      .target  (target)
   );

   mips_regfile regfile_i (
      .clk     (clk),
      .rst_b   (rst_b),
      .rs_idx  (inst.rs),
      .rt_idx  (inst.rt),
      .wr_idx  (wr_reg),
      .wr_data (wr_data),
      .we      (ctrl.reg_we),
      .rs_data (rs_data),
      .rt_data (rt_data)
   );

   mips_alu alu_i (
      .rs_data     (rs_data),
      .rt_data     (rt_data),
      .imm         (imm),
      .shamt       (inst.shamt),
      .alu_sel     (ctrl.alu_sel),
      .alu_src_imm (ctrl.alu_src_imm),
      .alu_result  (alu_result)
   );

   mips_pc_unit pc_unit_i (
      .clk      (clk),
      .rst_b    (rst_b),
      .pc_sel   (ctrl.pc_sel),
      .branch   (ctrl.branch),
      .syscall  (ctrl.syscall),
      .rs_data  (rs_data),
      .rt_data  (rt_data),
      .imm      (imm),
      .target   (target),
      .pc       (pc),
      .pc_plus4 (pc_plus4),
      .halted   (halted)
   );

   mips_writeback writeback_i (
      .load_sel   (ctrl.load_sel),
      .wb_sel     (ctrl.wb_sel),
      .alu_result (alu_result),
      .dmem_rdata (dmem_rdata),
      .imm        (imm),
      .pc_plus4   (pc_plus4),
      .wr_data    (wr_data)
   );

   assign inst_addr = pc[31:2];  // word address into rom

   // store port, word aligned address from the alu
   assign dmem_req = '{addr: alu_result[31:2], wdata: rt_data, we: ctrl.mem_we};

endmodule

/* logic/mips_writeback.sv */
// ------------------------------
// mips writeback
// load extraction and extension, lui value,
// register write data select
// ------------------------------
`timescale 1ns/100ps

module mips_writeback (
   input  mips_core_pkg::load_sel_e load_sel,
   input  mips_core_pkg::wb_sel_e   wb_sel,
   input  mips_isa_pkg::word_t      alu_result,
   input  mips_isa_pkg::word_t      dmem_rdata,
   input  mips_isa_pkg::word_t      imm,
   input  mips_isa_pkg::word_t      pc_plus4,
   output mips_isa_pkg::word_t      wr_data
);
   import mips_isa_pkg::*;
   import mips_core_pkg::*;

   word_t load_data;

   // narrow loads always take the low byte/half, offset ignored
   always_comb begin
      case (load_sel)
         LD_LB:   load_data = {{24{dmem_rdata[7]}}, dmem_rdata[7:0]};
         LD_LBU:  load_data = {24'h00_0000, dmem_rdata[7:0]};
         LD_LH:   load_data = {{16{dmem_rdata[15]}}, dmem_rdata[15:0]};
         LD_LHU:  load_data = {16'h0000, dmem_rdata[15:0]};
         LD_LUI:  load_data = {imm[15:0], 16'h0000};
         default: load_data = dmem_rdata;  // lw
      endcase
   end

   always_comb begin
      case (wb_sel)
         WB_LOAD: wr_data = load_data;
         WB_LINK: wr_data = pc_plus4;  // jal, no delay slot
         default: wr_data = alu_result;
      endcase
   end

endmodule

/* logic/mips_pc_unit.sv */
// ------------------------------
// mips pc unit
// branch compare, next pc mux, pc register
// and halt flag set by syscall
// ------------------------------
`timescale 1ns/100ps
`include "mips_macros.svh"

module mips_pc_unit (
   input  logic                    clk,
   input  logic                    rst_b,
   input  mips_core_pkg::pc_sel_e  pc_sel,
   input  mips_core_pkg::branch_e  branch,
   input  logic                    syscall,
   input  mips_isa_pkg::word_t     rs_data,
   input  mips_isa_pkg::word_t     rt_data,
   input  mips_isa_pkg::word_t     imm,
   input  logic [25:0]             target,
   output mips_isa_pkg::word_t     pc,
   output mips_isa_pkg::word_t     pc_plus4,
   output logic                    halted
);
   import mips_isa_pkg::*;
   import mips_core_pkg::*;

   word_t br_target, jump_target, pc_next;
   logic  taken;

   assign pc_plus4    = pc + 32'd4;
   assign br_target   = pc_plus4 + {imm[29:0], 2'b00};  // word offset
   assign jump_target = {pc[31:28], target, 2'b00};

   always_comb begin
      case (branch)
         BR_EQ:   taken = (rs_data == rt_data);
         BR_NE:   taken = (rs_data != rt_data);
         default: taken = 1'b0;
      endcase
   end

   always_comb begin
      case (pc_sel)
         PC_BRANCH: pc_next = taken ? br_target : pc_plus4;
         PC_REG:    pc_next = rs_data;  // jr
         PC_JUMP:   pc_next = jump_target;
         default:   pc_next = pc_plus4;
      endcase
   end

   // pc holds on the syscall itself and stays there
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc     <= `MIPS_TEXT_START;
         halted <= 1'b0;
      end else begin
         if (!halted && !syscall) pc <= pc_next;
         if (syscall) halted <= 1'b1;  // sticky until reset
      end
   end

endmodule

/* logic/mips_alu.sv */
// ------------------------------
// mips alu
// operand b select, add/sub, logic, signed compare
// and shifts; result doubles as data address
// ------------------------------
`timescale 1ns/100ps

module mips_alu (
   input  mips_isa_pkg::word_t      rs_data,
   input  mips_isa_pkg::word_t      rt_data,
   input  mips_isa_pkg::word_t      imm,
   input  logic [4:0]               shamt,
   input  mips_core_pkg::alu_sel_e  alu_sel,
   input  logic                     alu_src_imm,
   output mips_isa_pkg::word_t      alu_result
);
   import mips_isa_pkg::*;
   import mips_core_pkg::*;

   word_t op_b;
   logic [4:0] rs_sh;  // variable shift amount

   assign op_b  = alu_src_imm ? imm : rt_data;
   assign rs_sh = rs_data[4:0];

   always_comb begin
      case (alu_sel)
         ALU_ADD:  alu_result = rs_data + op_b;  // also load/store address
         ALU_SUB:  alu_result = rs_data - op_b;
         ALU_AND:  alu_result = rs_data & op_b;
         ALU_OR:   alu_result = rs_data | op_b;
         ALU_XOR:  alu_result = rs_data ^ op_b;
         ALU_NOR:  alu_result = ~(rs_data | op_b);
         ALU_SLT:  alu_result = ($signed(rs_data) < $signed(op_b)) ? 32'd1 : 32'd0;
         ALU_SLL:  alu_result = op_b << shamt;  // shifts act on rt
         ALU_SRL:  alu_result = op_b >> shamt;
         ALU_SRA:  alu_result = $signed(op_b) >>> shamt;
         ALU_SLLV: alu_result = op_b << rs_sh;
         ALU_SRLV: alu_result = op_b >> rs_sh;
         default:  alu_result = '0;
      endcase
   end

endmodule

/* logic/mips_regfile.sv */
// ------------------------------
// mips register file
// 32 x 32, two async read ports, one write port
// r0 reads zero, writes to it are dropped
// ------------------------------
`timescale 1ns/100ps
`include "mips_macros.svh"

module mips_regfile (
   input  logic                   clk,
   input  logic                   rst_b,
   input  mips_isa_pkg::reg_idx_t rs_idx,
   input  mips_isa_pkg::reg_idx_t rt_idx,
   input  mips_isa_pkg::reg_idx_t wr_idx,
   input  mips_isa_pkg::word_t    wr_data,
   input  logic                   we,
   output mips_isa_pkg::word_t    rs_data,
   output mips_isa_pkg::word_t    rt_data
);
   import mips_isa_pkg::*;

   word_t regs [`MIPS_NUM_REGS];

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (we && (wr_idx != '0)) begin
         regs[wr_idx] <= wr_data;  // r0 never written
      end
   end

   // combinational read, no bypass needed in single cycle
   assign rs_data = (rs_idx == '0) ? '0 : regs[rs_idx];
   assign rt_data = (rt_idx == '0) ? '0 : regs[rt_idx];

endmodule

/* logic/mips_decode.sv */
// ------------------------------
// mips instruction decoder
// opcode/funct to control word, immediate extension,
// destination register, write blocking after halt
// ------------------------------
`timescale 1ns/100ps
`include "mips_macros.svh"

module mips_decode (
   input  mips_isa_pkg::instr_t   inst,
   input  logic                   halted,
   output mips_core_pkg::ctrl_t   ctrl,
   output mips_isa_pkg::word_t    imm,
   output mips_isa_pkg::reg_idx_t wr_reg,
   output logic [25:0]            target
);
   import mips_isa_pkg::*;
   import mips_core_pkg::*;

   assign target = inst[25:0];  // j/jal field

   always_comb begin
      // default is a no-op
      ctrl = '{reg_we: 1'b0, alu_sel: ALU_ADD, alu_src_imm: 1'b0, imm_signed: 1'b1,
               load_sel: LD_LW, wb_sel: WB_ALU, pc_sel: PC_SEQ, branch: BR_NONE,
               mem_we: 1'b0, syscall: 1'b0};
      wr_reg = inst.rt;  // i-type dest

      case (inst.op)
         OP_SPECIAL: begin
            wr_reg = inst.rd;
            ctrl.reg_we = 1'b1;
            case (inst.funct)
               FN_ADDU: ctrl.alu_sel = ALU_ADD;
               FN_SUBU: ctrl.alu_sel = ALU_SUB;
               FN_AND:  ctrl.alu_sel = ALU_AND;
               FN_OR:   ctrl.alu_sel = ALU_OR;
               FN_XOR:  ctrl.alu_sel = ALU_XOR;
               FN_NOR:  ctrl.alu_sel = ALU_NOR;
               FN_SLT:  ctrl.alu_sel = ALU_SLT;
               FN_SLL:  ctrl.alu_sel = ALU_SLL;  // nop lands here, r0 dest
               FN_SRL:  ctrl.alu_sel = ALU_SRL;
               FN_SRA:  ctrl.alu_sel = ALU_SRA;
               FN_SLLV: ctrl.alu_sel = ALU_SLLV;
               FN_SRLV: ctrl.alu_sel = ALU_SRLV;
               FN_JR: begin
                  ctrl.reg_we = 1'b0;
                  ctrl.pc_sel = PC_REG;
               end
               FN_SYSCALL: begin
                  ctrl.reg_we  = 1'b0;
                  ctrl.syscall = 1'b1;
               end
               default: ctrl.reg_we = 1'b0;  // unknown funct, no-op
            endcase
         end
         OP_ADDIU: begin
            ctrl.reg_we      = 1'b1;
            ctrl.alu_src_imm = 1'b1;
         end
         OP_SLTI: begin
            ctrl.reg_we      = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            ctrl.alu_sel     = ALU_SLT;
         end
         OP_ANDI, OP_ORI, OP_XORI: begin
            ctrl.reg_we      = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            ctrl.imm_signed  = 1'b0;  // logical imms zero-extend
            ctrl.alu_sel     = (inst.op == OP_ANDI) ? ALU_AND :
                               (inst.op == OP_ORI)  ? ALU_OR  : ALU_XOR;
         end
         OP_LUI: begin
            ctrl.reg_we   = 1'b1;
            ctrl.load_sel = LD_LUI;
            ctrl.wb_sel   = WB_LOAD;
         end
         OP_LW, OP_LB, OP_LBU, OP_LH, OP_LHU: begin
            ctrl.reg_we      = 1'b1;
            ctrl.alu_src_imm = 1'b1;  // rs + offset
            ctrl.wb_sel      = WB_LOAD;
            ctrl.load_sel    = (inst.op == OP_LB)  ? LD_LB  :
                               (inst.op == OP_LBU) ? LD_LBU :
                               (inst.op == OP_LH)  ? LD_LH  :
                               (inst.op == OP_LHU) ? LD_LHU : LD_LW;
         end
         OP_SW: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.mem_we      = 1'b1;
         end
         OP_BEQ, OP_BNE: begin
            ctrl.pc_sel = PC_BRANCH;
            ctrl.branch = (inst.op == OP_BEQ) ? BR_EQ : BR_NE;
         end
         OP_J:  ctrl.pc_sel = PC_JUMP;
         OP_JAL: begin
            ctrl.pc_sel = PC_JUMP;
            ctrl.reg_we = 1'b1;
            ctrl.wb_sel = WB_LINK;
            wr_reg      = `MIPS_REG_RA;
         end
         default: ;  // reserved opcodes retire silently
      endcase

      imm = ctrl.imm_signed ? {{16{inst[15]}}, inst[15:0]} : {16'h0000, inst[15:0]};

      // halted core may not touch state
      if (halted) begin
         ctrl.reg_we = 1'b0;
         ctrl.mem_we = 1'b0;
      end
   end

endmodule

/* logic/mips_core_pkg.sv */
// ------------------------------
// mips core package
// control word and selector encodings of this
// single-cycle implementation, data memory request
// ------------------------------
package mips_core_pkg;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
      ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV
   } alu_sel_e;

   // load extraction, lui rides the same path
   typedef enum logic [2:0] {
      LD_LW, LD_LB, LD_LBU, LD_LH, LD_LHU, LD_LUI
   } load_sel_e;

   typedef enum logic [1:0] {
      WB_ALU, WB_LOAD, WB_LINK  // link = pc+4
   } wb_sel_e;

   typedef enum logic [1:0] {
      PC_SEQ, PC_BRANCH, PC_REG, PC_JUMP
   } pc_sel_e;

   typedef enum logic [1:0] {
      BR_NONE, BR_EQ, BR_NE
   } branch_e;

   typedef struct packed {
      logic      reg_we;
      alu_sel_e  alu_sel;
      logic      alu_src_imm;  // operand b from imm
      logic      imm_signed;   // decode internal
      load_sel_e load_sel;
      wb_sel_e   wb_sel;
      pc_sel_e   pc_sel;
      branch_e   branch;
      logic      mem_we;
      logic      syscall;
   } ctrl_t;

   // single word port, word addressed
   typedef struct packed {
      logic [29:0]         addr;
      mips_isa_pkg::word_t wdata;
      logic                we;
   } dmem_req_t;

endpackage

/* logic/mips_isa_pkg.sv */
// ------------------------------
// mips isa package
// architectural types, instruction fields and the opcode
// and funct encodings of the supported subset
// ------------------------------
`include "mips_macros.svh"

package mips_isa_pkg;

   typedef logic [`MIPS_XLEN-1:0] word_t;
   typedef logic [4:0]            reg_idx_t;

   // primary opcodes, anything else retires as a no-op
   typedef enum logic [5:0] {
      OP_SPECIAL = 6'h00,  // r-type, decoded on funct
      OP_J       = 6'h02,
      OP_JAL     = 6'h03,
      OP_BEQ     = 6'h04,
      OP_BNE     = 6'h05,
      OP_ADDIU   = 6'h09,
      OP_SLTI    = 6'h0a,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f,
      OP_LB      = 6'h20,
      OP_LH      = 6'h21,
      OP_LW      = 6'h23,
      OP_LBU     = 6'h24,
      OP_LHU     = 6'h25,
      OP_SW      = 6'h2b
   } opcode_e;

   // funct field of OP_SPECIAL
   typedef enum logic [5:0] {
      FN_SLL     = 6'h00,
      FN_SRL     = 6'h02,
      FN_SRA     = 6'h03,
      FN_SLLV    = 6'h04,
      FN_SRLV    = 6'h06,
      FN_JR      = 6'h08,
      FN_SYSCALL = 6'h0c,
      FN_ADDU    = 6'h21,
      FN_SUBU    = 6'h23,
      FN_AND     = 6'h24,
      FN_OR      = 6'h25,
      FN_XOR     = 6'h26,
      FN_NOR     = 6'h27,
      FN_SLT     = 6'h2a
   } funct_e;

   // r-type layout; imm is bits 15:0, jump target bits 25:0
   typedef struct packed {
      opcode_e  op;
      reg_idx_t rs;
      reg_idx_t rt;
      reg_idx_t rd;
      logic [4:0] shamt;
      funct_e   funct;
   } instr_t;

endpackage

/* include/mips_macros.svh */
// ------------------------------
// mips core constants
// word width, register file size, link register and reset pc
// ------------------------------
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// data path width
`define MIPS_XLEN 32

// gpr count, r0 included
`define MIPS_NUM_REGS 32

// jal destination
`define MIPS_REG_RA 5'd31

// first instruction after reset, start of .text
`define MIPS_TEXT_START 32'h0040_0000

`endif
